// File: design/cpuPkg.sv
// widths, opcode/alu/state enums, control word, load port, store event and status structs
`default_nettype none

package cpuPkg;

  typedef logic [3:0] dataT;  // A, B and TMP nibble
  typedef logic [3:0] addrT;  // 16-word address space
  typedef logic [7:0] wordT;  // opcode in [7:4], operand in [3:0]

  // upper nibble of an instruction word; unlisted codes behave as no-ops
  typedef enum logic [3:0] {
    opNop      = 4'b0000,
    opAdd      = 4'b0001,
    opSub      = 4'b0010,
    opExchange = 4'b0011,
    opStoreA   = 4'b0110,
    opLoadA    = 4'b0111,
    opAnd      = 4'b1000,
    opOrB      = 4'b1001
  } opcodeT;

  typedef enum logic [1:0] {
    aluAdd = 2'd0,
    aluSub = 2'd1,
    aluAnd = 2'd2,
    aluOr  = 2'd3
  } aluOpT;

  // one-hot ring, one bit per T state
  typedef enum logic [5:0] {
    stT1 = 6'b000001,
    stT2 = 6'b000010,
    stT3 = 6'b000100,
    stT4 = 6'b001000,
    stT5 = 6'b010000,
    stT6 = 6'b100000
  } tStateT;

  typedef struct packed {
    logic  loadMarFromPc;
    logic  incPc;
    logic  loadIr;
    logic  loadMarFromIr;
    logic  loadAFromMem;
    logic  loadAFromB;
    logic  loadAFromAlu;
    logic  loadTmpFromA;
    logic  loadTmpFromMem;
    logic  loadBFromTmp;
    logic  loadBFromAlu;
    logic  writeMem;
    aluOpT aluOp;
  } controlWordT;

  // program load port, honoured only while reset is held
  typedef struct packed {
    logic enable;
    addrT addr;
    wordT data;
  } memLoadT;

  typedef struct packed {
    logic strobe;
    addrT addr;
    dataT data;  // upper nibble of the stored word is always zero
  } storeEventT;

  typedef struct packed {
    addrT   pc;
    dataT   a;
    dataT   b;
    logic   retire;
    opcodeT retiredOpcode;
  } cpuStatusT;

endpackage

`default_nettype wire

// File: design/controlSequencer.sv
// six-state ring sequencer, instruction register and control word decode
`default_nettype none

module controlSequencer
  import cpuPkg::*;
(
  input  wire logic   clk,
  input  wire logic   reset,
  input  wire wordT   memWord,
  output controlWordT ctrl,
  output addrT        operand,
  output logic        retire,
  output opcodeT      retiredOpcode
);

  tStateT state;
  wordT   ir;
  opcodeT opcode;

  // ring counter, T6 wraps back to T1
  always_ff @(posedge clk)
  begin
    if (!reset)
      state <= stT1;
    else
      state <= tStateT'({state[4:0], state[5]});
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
      ir <= '0;  // opNop
    else if (ctrl.loadIr)
      ir <= memWord;
  end

  assign opcode        = opcodeT'(ir[7:4]);
  assign operand       = ir[3:0];
  assign retiredOpcode = opcode;
  assign retire        = (state == stT6);  // one pulse per instruction

  always_comb
  begin
    ctrl = '0;
    case (state)
      stT1: ctrl.loadMarFromPc = 1'b1;  // fetch address
      stT2: ctrl.incPc = 1'b1;
      stT3: ctrl.loadIr = 1'b1;
      stT4:
      begin
        case (opcode)
          opLoadA, opStoreA, opOrB: ctrl.loadMarFromIr = 1'b1;
          opExchange:               ctrl.loadTmpFromA = 1'b1;
          default:                  ;
        endcase
      end
      stT5:
      begin
        case (opcode)
          opLoadA:    ctrl.loadAFromMem = 1'b1;
          opExchange: ctrl.loadAFromB = 1'b1;
          opAdd:
          begin
            ctrl.aluOp        = aluAdd;
            ctrl.loadAFromAlu = 1'b1;
          end
          opSub:
          begin
            ctrl.aluOp        = aluSub;
            ctrl.loadAFromAlu = 1'b1;
          end
          opAnd:
          begin
            ctrl.aluOp        = aluAnd;
            ctrl.loadAFromAlu = 1'b1;
          end
          opStoreA:   ctrl.writeMem = 1'b1;
          opOrB:      ctrl.loadTmpFromMem = 1'b1;  // operand fetched into TMP first
          default:    ;
        endcase
      end
      stT6:
      begin
        case (opcode)
          opExchange: ctrl.loadBFromTmp = 1'b1;  // old A lands in B
          opOrB:
          begin
            ctrl.aluOp        = aluOr;
            ctrl.loadBFromAlu = 1'b1;
          end
          default:    ;
        endcase
      end
      default: ;
    endcase
  end

  // ring must never lose or duplicate its token
  stateOneHot: assert property (@(posedge clk) disable iff (!reset) $onehot(state))
    else $error("sequencer state not one-hot: %b", state);

  // A and B each have a single writer per cycle
  singleALoad: assert property (@(posedge clk)
    $onehot0({ctrl.loadAFromMem, ctrl.loadAFromB, ctrl.loadAFromAlu}))
    else $error("more than one A load strobe");

  singleBLoad: assert property (@(posedge clk)
    $onehot0({ctrl.loadBFromTmp, ctrl.loadBFromAlu}))
    else $error("more than one B load strobe");

endmodule

`default_nettype wire

// File: design/addressUnit.sv
// program counter and memory address register with pc/operand source select
`default_nettype none

module addressUnit
  import cpuPkg::*;
#(
  parameter addrT startAddress = '0
)
(
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire controlWordT ctrl,
  input  wire addrT        operand,
  output addrT             pc,
  output addrT             memAddr
);

  addrT mar;

  // 4-bit count, wraps 15 -> 0 on its own
  always_ff @(posedge clk)
  begin
    if (!reset)
      pc <= startAddress;
    else if (ctrl.incPc)
      pc <= pc + addrT'(1);
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
      mar <= startAddress;
    else if (ctrl.loadMarFromPc)
      mar <= pc;       // instruction fetch
    else if (ctrl.loadMarFromIr)
      mar <= operand;  // data access
  end

  assign memAddr = mar;

  // fetch and operand addressing belong to different T states
  marSingleSource: assert property (@(posedge clk) disable iff (!reset)
    !(ctrl.loadMarFromPc && ctrl.loadMarFromIr))
    else $error("MAR loaded from pc and operand in the same cycle");

endmodule

`default_nettype wire

// File: design/programMemory.sv
// 16x8 program/data memory with reset-time load port and accumulator store
`default_nettype none

module programMemory
  import cpuPkg::*;
(
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire memLoadT     memLoad,
  input  wire controlWordT ctrl,
  input  wire addrT        memAddr,
  input  wire dataT        accumulator,
  output wordT             memWord,
  output storeEventT       store
);

  wordT mem [16];

  // load port only while held in reset, stores only while running
  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      if (memLoad.enable)
        mem[memLoad.addr] <= memLoad.data;
    end
    else if (ctrl.writeMem)
    begin
      mem[memAddr] <= {4'b0000, accumulator};
    end
  end

  assign memWord = mem[memAddr];  // asynchronous read

  // store is visible during the cycle it is written
  assign store.strobe = ctrl.writeMem;
  assign store.addr   = memAddr;
  assign store.data   = accumulator;

  // the sequencer sits in T1 throughout reset, so no store may collide with loading
  noStoreInReset: assert property (@(posedge clk) !reset |-> !ctrl.writeMem)
    else $error("memory store requested during reset");

endmodule

`default_nettype wire

// File: design/dataPath.sv
// A, B and TMP registers with the 4-bit ALU
`default_nettype none

module dataPath
  import cpuPkg::*;
(
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire controlWordT ctrl,
  input  wire wordT        memWord,
  output dataT             accumulator,
  output dataT             bValue
);

  dataT regA;
  dataT regB;
  dataT regTmp;
  dataT aluResult;
  dataT memNibble;

  assign memNibble = memWord[3:0];  // data words use the low nibble only

  // all results wrap modulo 16
  always_comb
  begin
    case (ctrl.aluOp)
      aluAdd:  aluResult = regA + regB;
      aluSub:  aluResult = regA - regB;
      aluAnd:  aluResult = regA & regB;
      aluOr:   aluResult = regTmp | regB;  // or into B goes through TMP
      default: aluResult = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
      regA <= '0;
    else if (ctrl.loadAFromMem)
      regA <= memNibble;
    else if (ctrl.loadAFromB)
      regA <= regB;
    else if (ctrl.loadAFromAlu)
      regA <= aluResult;
  end

  // TMP holds old A during an exchange or the memory operand for or into B
  always_ff @(posedge clk)
  begin
    if (!reset)
      regTmp <= '0;
    else if (ctrl.loadTmpFromA)
      regTmp <= regA;
    else if (ctrl.loadTmpFromMem)
      regTmp <= memNibble;
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
      regB <= '0;
    else if (ctrl.loadBFromTmp)
      regB <= regTmp;
    else if (ctrl.loadBFromAlu)
      regB <= aluResult;
  end

  assign accumulator = regA;
  assign bValue      = regB;

  singleTmpLoad: assert property (@(posedge clk)
    $onehot0({ctrl.loadTmpFromA, ctrl.loadTmpFromMem}))
    else $error("more than one TMP load strobe");

endmodule

`default_nettype wire

// File: design/cpuTop.sv
// top level of the accumulator CPU: sequencer, address unit, program memory, datapath
`default_nettype none

module cpuTop
  import cpuPkg::*;
#(
  parameter addrT startAddress = '0
)
(
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire memLoadT    memLoad,
  output cpuStatusT       status,
  output storeEventT      store
);

  controlWordT ctrl;
  addrT        operand;
  addrT        memAddr;
  addrT        pc;
  wordT        memWord;
  dataT        accumulator;
  dataT        bValue;
  logic        retire;
  opcodeT      retiredOpcode;

  controlSequencer sequencer (
    .clk           (clk),
    .reset         (reset),
    .memWord       (memWord),
    .ctrl          (ctrl),
    .operand       (operand),
    .retire        (retire),
    .retiredOpcode (retiredOpcode)
  );

  addressUnit #(
    .startAddress (startAddress)
  ) addrUnit (
    .clk     (clk),
    .reset   (reset),
    .ctrl    (ctrl),
    .operand (operand),
    .pc      (pc),
    .memAddr (memAddr)
  );

  programMemory memory (
    .clk         (clk),
    .reset       (reset),
    .memLoad     (memLoad),
    .ctrl        (ctrl),
    .memAddr     (memAddr),
    .accumulator (accumulator),
    .memWord     (memWord),
    .store       (store)
  );

  dataPath datapath (
    .clk         (clk),
    .reset       (reset),
    .ctrl        (ctrl),
    .memWord     (memWord),
    .accumulator (accumulator),
    .bValue      (bValue)
  );

  // visible architectural state
  assign status.pc            = pc;
  assign status.a             = accumulator;
  assign status.b             = bValue;
  assign status.retire        = retire;
  assign status.retiredOpcode = retiredOpcode;

endmodule

`default_nettype wire

// File: testbench/cpuModel.svh
// reference model state and step, random program builder and LFSR source
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH
`default_nettype none

wordT        programImage [16];  // image written through memLoad
wordT        modelMem [16];
addrT        modelPc;
dataT        modelA;
dataT        modelB;
logic [3:0]  lastOpcode;   // opcode of the instruction that just retired
wordT        pendingWord;  // word the DUT is executing right now
logic [31:0] lfsrState;

task automatic initModel();
  int i;
  for (i = 0; i < 16; i++)
    modelMem[i] = programImage[i];
  modelPc     = startAddr;
  modelA      = 4'h0;
  modelB      = 4'h0;
  lastOpcode  = 4'h0;
  pendingWord = modelMem[startAddr];
endtask

// one whole instruction, fetch before execute
task automatic stepModel();
  wordT word;
  addrT addr;
  word       = modelMem[modelPc];
  addr       = word[3:0];
  lastOpcode = word[7:4];
  modelPc    = modelPc + 4'd1;  // wraps 15 to 0
  case (word[7:4])
    4'b0111: modelA = modelMem[addr][3:0];           // load A
    4'b0011: {modelA, modelB} = {modelB, modelA};    // exchange
    4'b0001: modelA = modelA + modelB;
    4'b0010: modelA = modelA - modelB;
    4'b1000: modelA = modelA & modelB;
    4'b0110: modelMem[addr] = {4'h0, modelA};        // store A
    4'b1001: modelB = modelMem[addr][3:0] | modelB;  // or into B
    default: ;
  endcase
  pendingWord = modelMem[modelPc];
endtask

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsrNext(input logic [31:0] value);
  return {value[30:0], value[31] ^ value[21] ^ value[1] ^ value[0]};
endfunction

function automatic logic [7:0] takeBits(input int count);
  logic [7:0] bits;
  int         i;
  bits = '0;
  for (i = 0; i < count; i++)
  begin
    lfsrState = lfsrNext(lfsrState);  // one step per bit
    bits      = {bits[6:0], lfsrState[0]};
  end
  return bits;
endfunction

function automatic wordT randomWord();
  logic [2:0] pick;
  logic [3:0] opcode;
  logic [3:0] operand;
  pick = 3'(takeBits(3));
  case (pick)
    3'd0: opcode = 4'b0111;
    3'd1: opcode = 4'b0011;
    3'd2: opcode = 4'b0001;
    3'd3: opcode = 4'b0010;
    3'd4: opcode = 4'b1000;
    3'd5: opcode = 4'b0110;
    3'd6: opcode = 4'b1001;
    default: opcode = 4'(takeBits(4));  // mostly undefined codes
  endcase
  operand = 4'(takeBits(4));
  return {opcode, operand};
endfunction

task automatic buildRandomProgram();
  int i;
  for (i = 0; i < 16; i++)
    programImage[i] = randomWord();
endtask

`default_nettype wire
`endif

// File: testbench/cpuTb.sv
// testbench for cpuTop: clock, program loading, model-based concurrent checks, watchdog
`default_nettype none

module cpuTb
  import cpuPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam addrT startAddr       = 4'd0;
  localparam int   numRandom       = 4;
  localparam int   numPrograms     = 3 + numRandom;
  localparam int   instrPerProgram = 40;
  localparam int   resetCycles     = 5;
  localparam int   watchdogNs      = numPrograms * instrPerProgram * 6 * 100 + 20_000;

  logic       clk;
  logic       reset;
  memLoadT    memLoad;
  cpuStatusT  status;
  storeEventT store;

`include "cpuModel.svh"

  cpuTop #(
    .startAddress (startAddr)
  ) UUT (
    .clk     (clk),
    .reset   (reset),
    .memLoad (memLoad),
    .status  (status),
    .store   (store)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic reportMismatch(input string signalName, input logic [3:0] expected,
                                input logic [3:0] actual);
    $display("FAIL at %t: %s expected %h, got %h", $time, signalName, expected, actual);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic reportFailure(input string what);
    $display("%s at %t", what, $time);
    $display("Test FAILED");
    $fatal(1);
  endtask

  // hold reset, write the image, release and wait for the retires
  task automatic loadAndRun();
    int retired;
    int i;
    @(negedge clk);
    reset = 1'b0;
    repeat (resetCycles) @(negedge clk);
    for (i = 0; i < 16; i++)
    begin
      memLoad.enable = 1'b1;
      memLoad.addr   = addrT'(i);
      memLoad.data   = programImage[i];
      @(negedge clk);
    end
    memLoad = '0;
    initModel();
    reset   = 1'b1;
    retired = 0;
    while (retired < instrPerProgram)
    begin
      @(negedge clk);
      if (status.retire === 1'b1)
        retired++;
    end
    repeat (2) @(negedge clk);  // post-retire checks sample first
  endtask

  // model advances mid T6, ahead of the edge that ends the instruction
  always @(negedge clk)
  begin
    if (status.retire === 1'b1)
      stepModel();
  end

  resetPc: assert property (@(posedge clk) !reset |=> status.pc == startAddr)
    else reportMismatch("status.pc", startAddr, $sampled(status.pc));
  resetA: assert property (@(posedge clk) !reset |=> status.a == 4'h0)
    else reportMismatch("status.a", 4'h0, $sampled(status.a));
  resetB: assert property (@(posedge clk) !reset |=> status.b == 4'h0)
    else reportMismatch("status.b", 4'h0, $sampled(status.b));
  resetRetire: assert property (@(posedge clk) !reset |=> !status.retire)
    else reportFailure("retire pulsed while reset was held");
  resetStore: assert property (@(posedge clk) !reset |=> !store.strobe)
    else reportFailure("store strobe raised while reset was held");

  firstRetire: assert property (@(posedge clk)
    $rose(reset) |-> !status.retire [*5] ##1 status.retire)
    else reportFailure("first retire not in the sixth cycle after reset release");
  retirePeriod: assert property (@(posedge clk) disable iff (!reset)
    status.retire |=> !status.retire [*5] ##1 status.retire)
    else reportFailure("retire not one cycle wide or not every six cycles");

  retiredOp: assert property (@(posedge clk) disable iff (!reset)
    status.retire |-> status.retiredOpcode == lastOpcode)
    else reportMismatch("status.retiredOpcode", $sampled(lastOpcode),
                        $sampled(status.retiredOpcode));
  retiredPc: assert property (@(posedge clk) disable iff (!reset)
    status.retire |=> status.pc == modelPc)
    else reportMismatch("status.pc", $sampled(modelPc), $sampled(status.pc));
  retiredA: assert property (@(posedge clk) disable iff (!reset)
    status.retire |=> status.a == modelA)
    else reportMismatch("status.a", $sampled(modelA), $sampled(status.a));
  retiredB: assert property (@(posedge clk) disable iff (!reset)
    status.retire |=> status.b == modelB)
    else reportMismatch("status.b", $sampled(modelB), $sampled(status.b));

  // stores are checked in T5, before the model takes the instruction
  storeOpcode: assert property (@(posedge clk) disable iff (!reset)
    store.strobe |-> pendingWord[7:4] == 4'b0110)
    else reportFailure("store strobe raised for an instruction that is not store A");
  storeAddr: assert property (@(posedge clk) disable iff (!reset)
    store.strobe |-> store.addr == pendingWord[3:0])
    else reportMismatch("store.addr", $sampled(pendingWord[3:0]), $sampled(store.addr));
  storeData: assert property (@(posedge clk) disable iff (!reset)
    store.strobe |-> store.data == modelA)
    else reportMismatch("store.data", $sampled(modelA), $sampled(store.data));
  storeInT5: assert property (@(posedge clk) disable iff (!reset)
    store.strobe |=> status.retire)
    else reportFailure("store strobe outside the cycle before retire");
  storeNotMissed: assert property (@(posedge clk) disable iff (!reset)
    (status.retire && lastOpcode == 4'b0110) |-> $past(store.strobe))
    else reportFailure("store A retired without a store strobe");

  initial
  begin
    $timeformat(-9, 1, " ns", 10);
    reset       = 1'b0;
    memLoad     = '0;
    lfsrState   = 32'hdbc9;
    // load 9, exchange, load 10, and, store 11, or into B from 11
    programImage = '{8'h79, 8'h30, 8'h7A, 8'h80, 8'h6B, 8'h9B, 8'h00, 8'h00,
                     8'h00, 8'h03, 8'h0B, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
    loadAndRun();
    // add and subtract chains that overflow and underflow
    programImage = '{8'h7E, 8'h30, 8'h7D, 8'h10, 8'h10, 8'h30, 8'h7F, 8'h20,
                     8'h20, 8'h20, 8'h10, 8'h30, 8'h20, 8'h09, 8'hAF, 8'hC2};
    loadAndRun();
    // stores over later instructions, then loads back
    programImage = '{8'h7E, 8'h30, 8'h7F, 8'h10, 8'h6C, 8'h7C, 8'h20, 8'h6D,
                     8'h9D, 8'h7D, 8'h6E, 8'h80, 8'h7E, 8'h3F, 8'h55, 8'hDC};
    loadAndRun();
    repeat (numRandom)
    begin
      buildRandomProgram();
      loadAndRun();
    end
    $display("Test OK");
    $finish;
  end

  // ends a run whose retire pulses have stopped
  initial
  begin
    #(watchdogNs);
    reportFailure("watchdog expired, retire pulses stopped");
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+testbench
design/cpuPkg.sv
design/controlSequencer.sv
design/addressUnit.sv
design/programMemory.sv
design/dataPath.sv
design/cpuTop.sv
testbench/cpuTb.sv
